// ==== Bender.yml ====
package:
  name: l15_port_arbiter

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/l15_pkg.sv
      - common/arb_pkg.sv
      - design/port_arb_fsm.sv
      - l15_io/l15_resp_router.sv
      - l15_io/l15_req_mux.sv
      - design/l15_port_arbiter.sv
  - target: test
    files:
      - test/arb_assertions.sv
      - test/tb_l15_port_arbiter.sv

// ==== common/arb_macros.svh ====
`ifndef ARB_MACROS_SVH
`define ARB_MACROS_SVH

// L1.5 message field widths
`define L15_ADDR_W    32
`define L15_DATA_W    64
`define L15_RQTYPE_W  5
`define L15_SIZE_W    3
`define L15_RTYPE_W   4   // Narrowed from the 32-bit bus field

// Fetch requests allowed in flight at once
`define ARB_MAX_FETCH 4

`endif

// ==== common/arb_pkg.sv ====
`default_nettype none

`include "arb_macros.svh"

package arb_pkg;

	// Who owns the shared L1.5 port
	typedef enum logic [1:0]
	{
		ARB_FETCH = 2'd0,   // Default owner
		ARB_WAIT  = 2'd1,   // Fetch responses still draining
		ARB_DATA  = 2'd2
	} arb_state_t;

	// Outstanding fetch count, must reach ARB_MAX_FETCH
	typedef logic [$clog2(`ARB_MAX_FETCH+1)-1:0] fetch_cnt_t;

endpackage

`default_nettype wire

// ==== common/l15_pkg.sv ====
`default_nettype none

`include "arb_macros.svh"

package l15_pkg;

	// Request address
	typedef logic [`L15_ADDR_W-1:0] l15_addr_t;

	// One data word, request payload or response half
	typedef logic [`L15_DATA_W-1:0] l15_data_t;

	typedef logic [`L15_RQTYPE_W-1:0] l15_rqtype_t;   // Request type
	typedef logic [`L15_SIZE_W-1:0] l15_size_t;       // Access size

	// Return type of a response
	typedef logic [`L15_RTYPE_W-1:0] l15_rtype_t;

endpackage

`default_nettype wire

// ==== design/l15_port_arbiter.sv ====
`default_nettype none

module l15_port_arbiter
(
	input  logic                 clk,
	input  logic                 nrst,

	// Shared L1.5 port
	output l15_pkg::l15_rqtype_t port_rqtype,
	output l15_pkg::l15_size_t   port_size,
	output l15_pkg::l15_addr_t   port_address,
	output l15_pkg::l15_data_t   port_data,
	output logic                 port_val,
	output logic                 port_req_ack,
	input  logic                 l15_ack,
	input  logic                 l15_header_ack,
	input  logic                 l15_val,
	input  l15_pkg::l15_data_t   l15_data_0,
	input  l15_pkg::l15_data_t   l15_data_1,
	input  l15_pkg::l15_rtype_t  l15_returntype,

	// Fetch requester
	input  l15_pkg::l15_rqtype_t fetch_rqtype,
	input  l15_pkg::l15_size_t   fetch_size,
	input  l15_pkg::l15_addr_t   fetch_address,
	input  l15_pkg::l15_data_t   fetch_data,
	input  logic                 fetch_val,
	input  logic                 fetch_req_ack,
	output logic                 fetch_ack,
	output logic                 fetch_header_ack,
	output logic                 fetch_resp_val,
	output l15_pkg::l15_data_t   fetch_data_0,
	output l15_pkg::l15_data_t   fetch_data_1,
	output l15_pkg::l15_rtype_t  fetch_returntype,
	output logic                 fetch_hold,

	// Data requester
	input  l15_pkg::l15_rqtype_t data_rqtype,
	input  l15_pkg::l15_size_t   data_size,
	input  l15_pkg::l15_addr_t   data_address,
	input  l15_pkg::l15_data_t   data_data,
	input  logic                 data_val,
	input  logic                 data_req_ack,
	output logic                 data_ack,
	output logic                 data_header_ack,
	output logic                 data_resp_val,
	output l15_pkg::l15_data_t   data_data_0,
	output l15_pkg::l15_data_t   data_data_1,
	output l15_pkg::l15_rtype_t  data_returntype,
	input  logic                 data_pending
);

	import arb_pkg::*;

	arb_state_t state;
	logic       fetch_idle;   // No fetch left in flight
	logic       data_done;

	port_arb_fsm i_port_arb_fsm
	(
		.clk          (clk),
		.nrst         (nrst),
		.data_pending (data_pending),
		.fetch_idle   (fetch_idle),
		.data_done    (data_done),
		.state        (state),
		.fetch_hold   (fetch_hold)
	);

	l15_resp_router i_l15_resp_router (.*);

	l15_req_mux i_l15_req_mux (.*);

endmodule

`default_nettype wire

// ==== design/port_arb_fsm.sv ====
`default_nettype none

module port_arb_fsm
(
	input  logic                clk,
	input  logic                nrst,
	input  logic                data_pending,
	input  logic                fetch_idle,
	input  logic                data_done,
	output arb_pkg::arb_state_t state,
	output logic                fetch_hold
);

	import arb_pkg::*;

	arb_state_t next_state;
	logic       served;   // Data operation answered during this ownership

	always_comb
	begin
		next_state = state;
		case (state)
			ARB_FETCH:
			begin
				if (data_pending)
					next_state = ARB_WAIT;
			end
			ARB_WAIT:
			begin
				// Hand over only once fetch responses are all back
				if (fetch_idle)
					next_state = ARB_DATA;
			end
			ARB_DATA:
			begin
				if (served && !data_pending)
					next_state = ARB_FETCH;
			end
			default:
				next_state = ARB_FETCH;
		endcase
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			state      <= ARB_FETCH;
			served     <= 1'b0;
			fetch_hold <= 1'b0;
		end
		else
		begin
			state      <= next_state;
			fetch_hold <= (next_state != ARB_FETCH);   // Tracks the state register
			if (state == ARB_DATA && next_state != ARB_DATA)
				served <= 1'b0;
			else if (data_done)
				served <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== l15_io/l15_req_mux.sv ====
`default_nettype none

module l15_req_mux
(
	input  arb_pkg::arb_state_t  state,
	input  l15_pkg::l15_rqtype_t fetch_rqtype,
	input  l15_pkg::l15_size_t   fetch_size,
	input  l15_pkg::l15_addr_t   fetch_address,
	input  l15_pkg::l15_data_t   fetch_data,
	input  l15_pkg::l15_rqtype_t data_rqtype,
	input  l15_pkg::l15_size_t   data_size,
	input  l15_pkg::l15_addr_t   data_address,
	input  l15_pkg::l15_data_t   data_data,
	input  logic                 fetch_val,
	input  logic                 data_val,
	input  logic                 fetch_req_ack,
	input  logic                 data_req_ack,
	input  logic                 l15_val,
	input  logic                 l15_ack,
	output l15_pkg::l15_rqtype_t port_rqtype,
	output l15_pkg::l15_size_t   port_size,
	output l15_pkg::l15_addr_t   port_address,
	output l15_pkg::l15_data_t   port_data,
	output logic                 port_val,
	output logic                 port_req_ack,
	output logic                 data_done
);

	import arb_pkg::*;

	logic data_owns;

	assign data_owns = (state == ARB_DATA);

	// Request fields follow the owner, fetch also during the drain
	assign port_rqtype  = data_owns ? data_rqtype : fetch_rqtype;
	assign port_size    = data_owns ? data_size : fetch_size;
	assign port_address = data_owns ? data_address : fetch_address;
	assign port_data    = data_owns ? data_data : fetch_data;
	assign port_req_ack = data_owns ? data_req_ack : fetch_req_ack;

	always_comb
	begin
		case (state)
			ARB_FETCH: port_val = fetch_val;
			ARB_DATA:  port_val = data_val;
			default:   port_val = 1'b0;   // Nothing new goes out while draining
		endcase
	end

	// Load answer or store ack ends the data operation
	assign data_done = data_owns && (l15_val || l15_ack);

endmodule

`default_nettype wire

// ==== l15_io/l15_resp_router.sv ====
`default_nettype none

`include "arb_macros.svh"

module l15_resp_router
(
	input  logic                clk,
	input  logic                nrst,
	input  arb_pkg::arb_state_t state,
	input  logic                fetch_val,
	input  logic                l15_header_ack,
	input  logic                l15_ack,
	input  logic                l15_val,
	input  l15_pkg::l15_data_t  l15_data_0,
	input  l15_pkg::l15_data_t  l15_data_1,
	input  l15_pkg::l15_rtype_t l15_returntype,
	output logic                fetch_ack,
	output logic                fetch_header_ack,
	output logic                fetch_resp_val,
	output l15_pkg::l15_data_t  fetch_data_0,
	output l15_pkg::l15_data_t  fetch_data_1,
	output l15_pkg::l15_rtype_t fetch_returntype,
	output logic                data_ack,
	output logic                data_header_ack,
	output logic                data_resp_val,
	output l15_pkg::l15_data_t  data_data_0,
	output l15_pkg::l15_data_t  data_data_1,
	output l15_pkg::l15_rtype_t data_returntype,
	output logic                fetch_idle
);

	import arb_pkg::*;

	fetch_cnt_t fetch_cnt;
	logic       data_owns;
	logic       fetch_issue;   // Fetch request taken by the port
	logic       fetch_answer;

	assign data_owns = (state == ARB_DATA);

	// Responses stay with fetch through the drain
	assign fetch_ack        = !data_owns && l15_ack;
	assign fetch_resp_val   = !data_owns && l15_val;
	assign fetch_data_0     = data_owns ? '0 : l15_data_0;
	assign fetch_data_1     = data_owns ? '0 : l15_data_1;
	assign fetch_returntype = data_owns ? '0 : l15_returntype;
	assign fetch_header_ack = (state == ARB_FETCH) && l15_header_ack;   // Masked in wait

	assign data_ack         = data_owns && l15_ack;
	assign data_header_ack  = data_owns && l15_header_ack;
	assign data_resp_val    = data_owns && l15_val;
	assign data_data_0      = data_owns ? l15_data_0 : '0;
	assign data_data_1      = data_owns ? l15_data_1 : '0;
	assign data_returntype  = data_owns ? l15_returntype : '0;

	assign fetch_issue  = fetch_header_ack && fetch_val;
	assign fetch_answer = fetch_resp_val;

	// Fetch requests accepted and not yet answered
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			fetch_cnt <= '0;
		else if (fetch_issue && !fetch_answer)
		begin
			if (fetch_cnt != fetch_cnt_t'(`ARB_MAX_FETCH))
				fetch_cnt <= fetch_cnt + 1'b1;
		end
		else if (fetch_answer && !fetch_issue)
		begin
			if (fetch_cnt != '0)
				fetch_cnt <= fetch_cnt - 1'b1;
		end
	end

	assign fetch_idle = (fetch_cnt == '0);

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+common
common/l15_pkg.sv
common/arb_pkg.sv
design/port_arb_fsm.sv
l15_io/l15_resp_router.sv
l15_io/l15_req_mux.sv
design/l15_port_arbiter.sv
test/arb_assertions.sv
test/tb_l15_port_arbiter.sv

// ==== test/arb_assertions.sv ====
`default_nettype none

module arb_assertions
(
	input logic                clk,
	input logic                nrst,
	input arb_pkg::arb_state_t state,
	input logic                fetch_hold,
	input logic                port_val,
	input logic                fetch_header_ack,
	input logic                data_header_ack,
	input logic                fetch_resp_val,
	input logic                data_resp_val
);

	timeunit 1ns;
	timeprecision 100ps;

	import arb_pkg::*;

	int n_fail = 0;   // Failed assertion attempts

	// Draining, fetch held and data not yet owner
	a_drain_quiet: assert property (@(posedge clk) disable iff (!nrst)
		(fetch_hold && state != ARB_DATA) |-> (!port_val && !data_header_ack))
	else
	begin
		$error("port request or data header ack during drain");
		n_fail++;
	end

	a_hold_no_hack: assert property (@(posedge clk) disable iff (!nrst)
		fetch_hold |-> !fetch_header_ack)
	else
	begin
		$error("fetch header ack while fetch is held");
		n_fail++;
	end

	a_one_resp: assert property (@(posedge clk) disable iff (!nrst)
		!(fetch_resp_val && data_resp_val))
	else
	begin
		$error("response valid on both sides");   // One owner per response
		n_fail++;
	end

endmodule

bind l15_port_arbiter arb_assertions i_arb_assertions (.*);

`default_nettype wire

// ==== test/tb_l15_port_arbiter.sv ====
`default_nettype none

module tb_l15_port_arbiter;

	timeunit 1ns;
	timeprecision 100ps;

	import l15_pkg::*;

	localparam int          N_TXN     = 300;
	localparam int          MAX_CYCLE = N_TXN * 40;
	localparam l15_data_t   PATTERN   = 64'h5a5a_c3c3_0ff0_9669;   // Response data key
	localparam l15_rqtype_t IMISS_RQ  = 5'h10;
	localparam l15_rqtype_t LOAD_RQ   = 5'h00;
	localparam l15_rtype_t  IFILL_RET = 4'h4;
	localparam l15_rtype_t  LOAD_RET  = 4'h0;

	typedef enum {OWN_FETCH, OWN_WAIT, OWN_DATA} owner_t;

	logic        clk;
	logic        nrst;
	l15_rqtype_t port_rqtype, fetch_rqtype, data_rqtype;
	l15_size_t   port_size, fetch_size, data_size;
	l15_addr_t   port_address, fetch_address, data_address;
	l15_data_t   port_data, fetch_data, data_data, l15_data_0, l15_data_1;
	l15_data_t   fetch_data_0, fetch_data_1, data_data_0, data_data_1;
	l15_rtype_t  l15_returntype, fetch_returntype, data_returntype;
	logic        port_val, port_req_ack, l15_ack, l15_header_ack, l15_val;
	logic        fetch_val, fetch_req_ack, fetch_ack, fetch_header_ack, fetch_resp_val;
	logic        data_val, data_req_ack, data_ack, data_header_ack, data_resp_val;
	logic        fetch_hold, data_pending;

	owner_t       owner, owner_next;   // Expected port owner
	bit           served, run, all_done, timed_out, exp_val;
	logic [104:0] exp_req;
	l15_addr_t    exp_addr;
	l15_addr_t    fetch_exp_q[$], data_exp_q[$], mem_addr_q[$];
	l15_rtype_t   mem_rtype_q[$];
	int           mem_due_q[$];
	int           checks[5], errs[5];
	string        names[5] = '{"reset", "fetch ownership", "drain", "data ownership", "return"};
	int           t, cycle, issued, fetch_acc, fetch_resp, returns, fetch_after_return;
	int           total_chk, total_err, failed_tests;

	l15_port_arbiter i_l15_port_arbiter (.*);

	initial
		clk = 1'b0;
	always
		#5 clk = ~clk;

	task automatic verify(input int test, input bit ok, input string msg);
		checks[test]++;
		assert (ok)
		else
		begin
			$display("** Error at %0t ns: %s: %s", $time, names[test], msg);
			errs[test]++;
		end
	endtask

	task automatic report_test(input int test);
		$display("Test %-16s %4d checks, %0d errors", names[test], checks[test], errs[test]);
	endtask

	initial
	begin
		void'($urandom(32'hfb86_34ca));
		nrst = 1'b0;
		fetch_rqtype = IMISS_RQ;
		data_rqtype = LOAD_RQ;
		{fetch_size, fetch_address, fetch_data, fetch_val, fetch_req_ack} = '0;
		{data_size, data_address, data_data, data_val, data_req_ack, data_pending} = '0;
		{l15_ack, l15_header_ack, l15_val, l15_data_0, l15_data_1, l15_returntype} = '0;
		owner = OWN_FETCH;
		repeat (5) @(posedge clk);
		nrst <= 1'b1;
		@(posedge clk);
		verify(0, {port_val, fetch_hold, fetch_ack, fetch_header_ack, fetch_resp_val,
			data_ack, data_header_ack, data_resp_val} == '0, "valid, ack or hold set after reset");
		report_test(0);
		run <= 1'b1;
		while (!all_done && !timed_out)
			@(negedge clk);
		if (timed_out)
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLE);
		verify(4, fetch_acc == fetch_resp,
			$sformatf("%0d fetch responses for %0d accepted", fetch_resp, fetch_acc));
		verify(4, fetch_after_return > 0, "no fetch request reached the port after a return");
		for (int i = 1; i < 5; i++)
			report_test(i);
		for (int i = 0; i < 5; i++)
		begin
			total_chk += checks[i];
			total_err += errs[i];
			failed_tests += int'(errs[i] != 0);
		end
		if (i_l15_port_arbiter.i_arb_assertions.n_fail != 0)
			$display("Bound assertions failed %0d times",
				i_l15_port_arbiter.i_arb_assertions.n_fail);
		total_err += i_l15_port_arbiter.i_arb_assertions.n_fail;
		$display("Tests: 5, failed: %0d; checks: %0d, errors: %0d; cycles: %0d",
			failed_tests, total_chk, total_err, cycle);
		if (total_err == 0 && !timed_out)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	always @(posedge clk)
	begin
		if (run)
		begin
			cycle++;
			if (cycle >= MAX_CYCLE)
				timed_out = 1'b1;
			t = (owner == OWN_FETCH) ? 1 : (owner == OWN_WAIT) ? 2 : 3;
			exp_val = (owner == OWN_FETCH) ? fetch_val : (owner == OWN_DATA) ? data_val : 1'b0;
			if (owner == OWN_DATA)
				exp_req = {data_rqtype, data_size, data_address, data_data, data_req_ack};
			else
				exp_req = {fetch_rqtype, fetch_size, fetch_address, fetch_data, fetch_req_ack};
			verify(t, port_val == exp_val, $sformatf("port_val %b, expected %b", port_val, exp_val));
			if (owner != OWN_WAIT)
				verify(t, {port_rqtype, port_size, port_address, port_data, port_req_ack} == exp_req,
					$sformatf("port request %h, expected %h",
					{port_rqtype, port_size, port_address, port_data, port_req_ack}, exp_req));
			verify(t, {fetch_header_ack, data_header_ack} == {owner == OWN_FETCH && l15_header_ack,
				owner == OWN_DATA && l15_header_ack}, "header ack routed to the wrong side");
			verify(t, {fetch_resp_val, fetch_ack, data_resp_val, data_ack} ==
				{owner != OWN_DATA && l15_val, owner != OWN_DATA && l15_ack,
				owner == OWN_DATA && l15_val, owner == OWN_DATA && l15_ack},
				"response valid or ack routed to the wrong side");
			verify(owner == OWN_FETCH ? 4 : 2, fetch_hold == (owner != OWN_FETCH),
				$sformatf("fetch_hold %b, expected %b", fetch_hold, owner != OWN_FETCH));

			// Ownership rules, on the values seen this cycle
			owner_next = owner;
			case (owner)
				OWN_FETCH:
					if (data_pending)
						owner_next = OWN_WAIT;
				OWN_WAIT:
					if (fetch_exp_q.size() == 0)
						owner_next = OWN_DATA;
				default:
					if (served && !data_pending)
						owner_next = OWN_FETCH;
			endcase
			if (owner == OWN_DATA && owner_next != OWN_DATA)
				served = 1'b0;
			else if (owner == OWN_DATA && (l15_val || l15_ack))
				served = 1'b1;

			if (l15_val && owner != OWN_DATA)
			begin
				exp_addr = fetch_exp_q.size() > 0 ? fetch_exp_q.pop_front() : '0;
				fetch_resp++;
				verify(1, fetch_data_0 == (l15_data_t'(exp_addr) ^ PATTERN) &&
					fetch_data_1 == ~l15_data_t'(exp_addr) && fetch_returntype == IFILL_RET,
					$sformatf("fetch data %h %h type %h, expected %h %h %h",
					fetch_data_0, fetch_data_1, fetch_returntype,
					l15_data_t'(exp_addr) ^ PATTERN, ~l15_data_t'(exp_addr), IFILL_RET));
			end
			if (l15_val && owner == OWN_DATA)
			begin
				exp_addr = data_exp_q.size() > 0 ? data_exp_q.pop_front() : '0;
				data_pending <= 1'b0;
				verify(3, data_data_0 == (l15_data_t'(exp_addr) ^ PATTERN) &&
					data_data_1 == ~l15_data_t'(exp_addr) && data_returntype == LOAD_RET,
					$sformatf("data data %h %h type %h, expected %h %h %h",
					data_data_0, data_data_1, data_returntype,
					l15_data_t'(exp_addr) ^ PATTERN, ~l15_data_t'(exp_addr), LOAD_RET));
			end

			// Requesters see acceptance through the expected owner
			if (owner == OWN_FETCH && fetch_val && l15_header_ack)
			begin
				fetch_exp_q.push_back(fetch_address);
				fetch_acc++;
				fetch_after_return += int'(returns > 0);
				fetch_val <= 1'b0;
			end
			if (owner == OWN_DATA && data_val && l15_header_ack)
			begin
				data_exp_q.push_back(data_address);
				data_val <= 1'b0;
			end
			fetch_req_ack <= l15_val && owner != OWN_DATA;
			data_req_ack  <= l15_val && owner == OWN_DATA;
			if (!fetch_val && issued < N_TXN && fetch_exp_q.size() < 3 && $urandom % 3 == 0)
			begin
				fetch_val     <= 1'b1;
				fetch_address <= $urandom & 32'hffff_fffc;
				fetch_size    <= l15_size_t'($urandom);
				issued++;
			end
			if (!data_pending && owner == OWN_FETCH && issued < N_TXN && $urandom % 16 == 0)
			begin
				data_pending <= 1'b1;
				data_val     <= 1'b1;
				data_address <= $urandom & 32'hffff_fff8;
				data_size    <= l15_size_t'($urandom);
				data_data    <= {$urandom, $urandom};
				issued++;
			end

			// L1.5 model, answers in order after a random latency
			l15_header_ack <= ($urandom % 3 != 0);
			l15_ack <= ($urandom % 8 == 0);   // Stray store acks
			l15_val <= 1'b0;
			if (port_val && l15_header_ack)
			begin
				if (port_rqtype == LOAD_RQ)
					verify(2, fetch_exp_q.size() == 0,
						"data request taken with fetches in flight");
				mem_addr_q.push_back(port_address);
				mem_rtype_q.push_back(port_rqtype == IMISS_RQ ? IFILL_RET : LOAD_RET);
				mem_due_q.push_back(cycle + 2 + $urandom % 8);
			end
			if (mem_due_q.size() > 0 && mem_due_q[0] <= cycle)
			begin
				l15_val        <= 1'b1;
				l15_data_0     <= l15_data_t'(mem_addr_q[0]) ^ PATTERN;
				l15_data_1     <= ~l15_data_t'(mem_addr_q[0]);
				l15_returntype <= mem_rtype_q.pop_front();
				void'(mem_addr_q.pop_front());
				void'(mem_due_q.pop_front());
			end

			returns += int'(owner == OWN_DATA && owner_next == OWN_FETCH);
			owner = owner_next;
			all_done = issued >= N_TXN && !fetch_val && !data_val && !data_pending &&
				fetch_exp_q.size() == 0 && data_exp_q.size() == 0 && owner == OWN_FETCH;
		end
	end

endmodule

`default_nettype wire
